// ==== compile.f ====
hdl/qspim_pkg.sv
hdl/qspim_addr_dec.sv
hdl/qspim_rd_fsm.sv
hdl/qspim_wb_resp.sv
hdl/qspim_if_top.sv
verif/qspim_if_properties.sv
verif/tb_qspim_if.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status reflects the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_qspim_if \
  -f compile.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
  echo "No result line in $LOG"
  exit 1
fi

exit 0

// ==== verif/tb_qspim_if.sv ====
// Testbench for the QSPI front end: bus models, mixed register and flash traffic, watchdog
module tb_qspim_if;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BL_W       = 10;
  localparam int CLK_PER    = 10;
  localparam int RST_CYC    = 8;
  localparam int N_TXN      = 24;  // Half register, half flash
  localparam int TIMEOUT_NS = RST_CYC * CLK_PER + N_TXN * 200;

  logic                                            mclk;
  logic                                            rst_n;
  logic                                            spi_init_done_i;
  qspim_pkg::wb_req_t                              wb_req;
  logic [BL_W-1:0]                                 wbd_bl_i;
  logic                                            wbd_bry_i;
  logic [31:0]                                     wbd_dat_o;
  logic                                            wbd_ack_o;
  logic                                            wbd_lack_o;
  qspim_pkg::spim_cs_map_t [qspim_pkg::NUM_CS-1:0] cs_map;
  qspim_pkg::spim_rd_cfg_t                         g0_cfg;
  qspim_pkg::spim_rd_cfg_t                         g1_cfg;
  logic                                            spim_reg_req_o;
  qspim_pkg::spim_reg_req_t                        spim_reg_o;
  logic                                            spim_reg_ack_i;
  logic [31:0]                                     spim_reg_rdata_i;
  logic                                            cmd_fifo_wr_o;
  logic [qspim_pkg::CMD_FIFO_WD-1:0]               cmd_fifo_wdata_o;
  logic                                            cmd_fifo_full_i;
  logic                                            cmd_fifo_empty_i;
  logic                                            res_fifo_rd_o;
  logic [31:0]                                     res_fifo_rdata_i;
  logic                                            res_fifo_empty_i;

  // Model state, sampled mid-cycle and applied after the next edge
  logic        reg_req_s, reg_ack_s, cmd_wr_s, eoc_s, res_rd_s, stb_s;
  int          cmd_cnt;
  int          drain_dly;
  int          res_pend;
  logic [31:0] res_q[$];

  qspim_if_top #(.BL_W(BL_W)) UUT (
    .mclk(mclk), .rst_n(rst_n), .spi_init_done_i(spi_init_done_i),
    .wb_req_i(wb_req), .wbd_bl_i(wbd_bl_i), .wbd_bry_i(wbd_bry_i),
    .wbd_dat_o(wbd_dat_o), .wbd_ack_o(wbd_ack_o), .wbd_lack_o(wbd_lack_o),
    .cs_map_i(cs_map), .g0_cfg_i(g0_cfg), .g1_cfg_i(g1_cfg),
    .spim_reg_req_o(spim_reg_req_o), .spim_reg_o(spim_reg_o),
    .spim_reg_ack_i(spim_reg_ack_i), .spim_reg_rdata_i(spim_reg_rdata_i),
    .cmd_fifo_wr_o(cmd_fifo_wr_o), .cmd_fifo_wdata_o(cmd_fifo_wdata_o),
    .cmd_fifo_full_i(cmd_fifo_full_i), .cmd_fifo_empty_i(cmd_fifo_empty_i),
    .res_fifo_rd_o(res_fifo_rd_o), .res_fifo_rdata_i(res_fifo_rdata_i),
    .res_fifo_empty_i(res_fifo_empty_i)
  );

  initial begin
    mclk = 1'b0;
    forever #(CLK_PER / 2) mclk = ~mclk;
  end

  //------------------------------------------------------------
  // Register slave, command FIFO and response FIFO models
  //------------------------------------------------------------
  always @(negedge mclk) begin
    reg_req_s = spim_reg_req_o;
    reg_ack_s = spim_reg_ack_i;
    cmd_wr_s  = cmd_fifo_wr_o;
    eoc_s     = cmd_fifo_wdata_o[48];  // Address word marker
    res_rd_s  = res_fifo_rd_o;
    stb_s     = wb_req.stb;
  end

  always @(posedge mclk) begin
    #1;
    spim_reg_ack_i   = reg_req_s && !reg_ack_s;  // One cycle after the request
    spim_reg_rdata_i = $urandom;
    if (cmd_wr_s) begin
      cmd_cnt++;
      drain_dly = 3;
      if (eoc_s) res_pend = int'(wbd_bl_i);  // Read data follows the address word
    end else if (cmd_cnt > 0) begin
      if (drain_dly > 0) drain_dly--;
      else cmd_cnt--;
    end else if (!stb_s && $urandom_range(0, 3) == 0) begin
      // Leftover command from another source holds off the next header
      cmd_cnt   = 1;
      drain_dly = 3;
    end
    cmd_fifo_empty_i = (cmd_cnt == 0);
    if (res_rd_s) void'(res_q.pop_front());
    if (res_pend > 0 && cmd_cnt == 0 && $urandom_range(0, 3) != 0) begin
      res_q.push_back($urandom);
      res_pend--;
    end
    res_fifo_empty_i = (res_q.size() == 0);
    res_fifo_rdata_i = res_fifo_empty_i ? 32'h0 : res_q[0];
    wbd_bry_i        = ($urandom_range(0, 3) != 0);  // Random stall gaps
  end

  // Holds stb until the last ack, then leaves the bus idle for two cycles
  task automatic run_access(input logic [31:0] adr, input logic we, input int bl);
    wb_req.adr = adr;
    wb_req.we  = we;
    wb_req.dat = $urandom;
    wb_req.sel = 4'hf;
    wbd_bl_i   = BL_W'(bl);
    wb_req.stb = 1'b1;
    do begin
      @(posedge mclk);
      #1;
    end while (!wbd_lack_o);
    wb_req.stb = 1'b0;
    repeat (2) @(posedge mclk);
    #1;
  endtask

  initial begin
    void'($urandom(32'had03_205e));
    rst_n            = 1'b0;
    spi_init_done_i  = 1'b0;
    wb_req           = '0;
    wbd_bl_i         = '0;
    wbd_bry_i        = 1'b0;
    spim_reg_ack_i   = 1'b0;
    spim_reg_rdata_i = '0;
    cmd_fifo_full_i  = 1'b0;
    cmd_fifo_empty_i = 1'b1;
    res_fifo_rdata_i = '0;
    res_fifo_empty_i = 1'b1;
    cmd_cnt          = 0;
    drain_dly        = 0;
    res_pend         = 0;
    g0_cfg = qspim_pkg::spim_rd_cfg_t'($urandom);
    g1_cfg = qspim_pkg::spim_rd_cfg_t'($urandom);
    for (int i = 0; i < 4; i++) begin
      cs_map[i].mask = 8'hc0 | (8'($urandom) & 8'h0c);     // Top bits pick the CS
      cs_map[i].addr = 8'(i << 6) | (8'($urandom) & cs_map[i].mask & 8'h0c);
    end
    repeat (RST_CYC) @(posedge mclk);
    #1;
    rst_n = 1'b1;
    spi_init_done_i = 1'b1;
    for (int t = 0; t < N_TXN / 2; t++) begin
      run_access(32'h1000_0000 | (32'($urandom) & 32'h3c), 1'($urandom), 1);
      run_access({4'h0, 8'($urandom), 18'($urandom), 2'b00}, 1'b0, $urandom_range(1, 6));
    end
    $display("Errors: %0d assertion failures, 0 timeouts", UUT.u_props.err_cnt);
    if (UUT.u_props.err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS * 1ns);
    $display("Timeout: traffic did not complete, %0d assertion failures, 1 timeout",
             UUT.u_props.err_cnt);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== verif/qspim_if_properties.sv ====
// Concurrent checks on the QSPI front end top level, bound into every qspim_if_top instance
module qspim_if_properties #(
  parameter int BL_W = 10
) (
  input logic                                            mclk,
  input logic                                            rst_n,
  input logic                                            spi_init_done_i,
  input qspim_pkg::wb_req_t                              wb_req_i,
  input logic [BL_W-1:0]                                 wbd_bl_i,
  input logic                                            wbd_bry_i,
  input logic [qspim_pkg::WB_W-1:0]                      wbd_dat_o,
  input logic                                            wbd_ack_o,
  input logic                                            wbd_lack_o,
  input qspim_pkg::spim_cs_map_t [qspim_pkg::NUM_CS-1:0] cs_map_i,
  input qspim_pkg::spim_rd_cfg_t                         g0_cfg_i,
  input qspim_pkg::spim_rd_cfg_t                         g1_cfg_i,
  input logic                                            spim_reg_req_o,
  input qspim_pkg::spim_reg_req_t                        spim_reg_o,
  input logic                                            spim_reg_ack_i,
  input logic [qspim_pkg::WB_W-1:0]                      spim_reg_rdata_i,
  input logic                                            cmd_fifo_wr_o,
  input logic [qspim_pkg::CMD_FIFO_WD-1:0]               cmd_fifo_wdata_o,
  input logic                                            cmd_fifo_empty_i,
  input logic                                            res_fifo_rd_o,
  input logic [qspim_pkg::WB_W-1:0]                      res_fifo_rdata_i,
  input logic                                            res_fifo_empty_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned              err_cnt = 0;   // Read by the testbench at the end
  qspim_pkg::spim_cmd_hdr_t hdr;
  qspim_pkg::spim_cmd_adr_t adr_w;
  logic                     prev_wr;
  logic                     hdr_wr;        // First word of a command pair
  logic [BL_W-1:0]          beat_cnt;      // Reads since the header
  logic                     last_beat;     // Next read ends the burst
  logic [3:0]               exp_cs;
  qspim_pkg::spim_rd_cfg_t  exp_cfg;
  logic                     exp_reg_req;
  qspim_pkg::spim_reg_req_t exp_reg_o;
  logic                     cfg_ok;

  assign hdr    = cmd_fifo_wdata_o;
  assign adr_w  = cmd_fifo_wdata_o;
  assign hdr_wr = cmd_fifo_wr_o && !prev_wr;

  //------------------------------------------------------------
  // Reference values from the address map rules
  //------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      exp_cs[i] = ((wb_req_i.adr[27:20] & cs_map_i[i].mask) == cs_map_i[i].addr);
    end
  end

  assign exp_cfg     = (exp_cs == 4'b0100 || exp_cs == 4'b1000) ? g1_cfg_i : g0_cfg_i;
  assign exp_reg_req = wb_req_i.stb && spi_init_done_i && wb_req_i.adr[28] && !wbd_lack_o;
  // Register bus fields come straight off the Wishbone request
  assign exp_reg_o   = '{addr: wb_req_i.adr[5:2], we: wb_req_i.we, be: wb_req_i.sel,
                         wdata: wb_req_i.dat};
  assign last_beat   = (beat_cnt == wbd_bl_i - 1'b1);
  assign cfg_ok = hdr.dummy_cnt == exp_cfg.dummy_cnt && hdr.addr_cnt == exp_cfg.addr_cnt &&
                  hdr.switch_pt == exp_cfg.switch_pt && hdr.fmode == exp_cfg.fmode &&
                  hdr.imode == exp_cfg.imode && hdr.seq == exp_cfg.seq &&
                  hdr.mode == exp_cfg.mode && hdr.cmd == exp_cfg.cmd;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      prev_wr  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      prev_wr <= cmd_fifo_wr_o;
      if (hdr_wr) beat_cnt <= '0;              // New burst
      else if (res_fifo_rd_o) beat_cnt <= beat_cnt + 1'b1;
    end
  end

  //------------------------------------------------------------
  // Reset and register bus
  //------------------------------------------------------------
  a_reset_quiet: assert property (@(posedge mclk)
    !rst_n |=> !wbd_ack_o && !wbd_lack_o && !cmd_fifo_wr_o && !res_fifo_rd_o)
    else begin err_cnt++; $error("Outputs active in the cycle after reset"); end

  a_reg_req: assert property (@(posedge mclk) disable iff (!rst_n)
    spim_reg_req_o == exp_reg_req)
    else begin
      err_cnt++;
      $error("Fail %0t spim_reg_req_o exp %b got %b", $time, exp_reg_req, spim_reg_req_o);
    end

  a_reg_fields: assert property (@(posedge mclk) disable iff (!rst_n)
    spim_reg_req_o |-> spim_reg_o == exp_reg_o)
    else begin
      err_cnt++;
      $error("Fail %0t spim_reg_o exp %h got %h", $time, exp_reg_o, spim_reg_o);
    end

  a_reg_ack: assert property (@(posedge mclk) disable iff (!rst_n)
    spim_reg_req_o && spim_reg_ack_i |=> wbd_ack_o && wbd_lack_o)
    else begin err_cnt++; $error("No Wishbone ack and last ack after register ack"); end

  a_reg_rdata: assert property (@(posedge mclk) disable iff (!rst_n)
    spim_reg_req_o && spim_reg_ack_i && !wb_req_i.we |=>
      wbd_dat_o == $past(spim_reg_rdata_i))
    else begin
      err_cnt++;
      $error("Fail %0t wbd_dat_o exp %h got %h", $time, $past(spim_reg_rdata_i), wbd_dat_o);
    end

  //------------------------------------------------------------
  // Command words
  //------------------------------------------------------------
  a_hdr_word: assert property (@(posedge mclk) disable iff (!rst_n)
    hdr_wr |-> hdr.soc && !hdr.eoc && hdr.byte_len == 12'(wbd_bl_i) * 12'd4 &&
               hdr.cs == exp_cs && cfg_ok)
    else begin
      err_cnt++;
      $error("Fail %0t cmd_fifo_wdata_o exp cs %b len %0d got cs %b len %0d", $time,
             exp_cs, 12'(wbd_bl_i) * 12'd4, hdr.cs, hdr.byte_len);
    end

  a_adr_word: assert property (@(posedge mclk) disable iff (!rst_n)
    hdr_wr |=> cmd_fifo_wr_o && adr_w.eoc && adr_w.adr == $past(wb_req_i.adr))
    else begin
      err_cnt++;
      $error("Fail %0t cmd_fifo_wdata_o exp wr 1 eoc 1 adr %h got wr %b eoc %b adr %h",
             $time, $past(wb_req_i.adr), cmd_fifo_wr_o, adr_w.eoc, adr_w.adr);
    end

  a_hdr_empty: assert property (@(posedge mclk) disable iff (!rst_n)
    hdr_wr |-> cmd_fifo_empty_i)
    else begin err_cnt++; $error("Header written into a non-empty command FIFO"); end

  //------------------------------------------------------------
  // Burst return and back-pressure
  //------------------------------------------------------------
  a_rd_legal: assert property (@(posedge mclk) disable iff (!rst_n)
    res_fifo_rd_o |-> wbd_bry_i && !res_fifo_empty_i)
    else begin err_cnt++; $error("Response read while stalled or FIFO empty"); end

  a_rd_ack: assert property (@(posedge mclk) disable iff (!rst_n)
    res_fifo_rd_o |=> wbd_ack_o && wbd_dat_o == $past(res_fifo_rdata_i))
    else begin
      err_cnt++;
      $error("Fail %0t wbd_dat_o exp %h got %h", $time, $past(res_fifo_rdata_i), wbd_dat_o);
    end

  a_rd_lack: assert property (@(posedge mclk) disable iff (!rst_n)
    res_fifo_rd_o |=> wbd_lack_o == $past(last_beat))
    else begin
      err_cnt++;
      $error("Fail %0t wbd_lack_o exp %b got %b", $time, $past(last_beat), wbd_lack_o);
    end

endmodule

bind qspim_if_top qspim_if_properties #(.BL_W(BL_W)) u_props (
  .mclk             (mclk),
  .rst_n            (rst_n),
  .spi_init_done_i  (spi_init_done_i),
  .wb_req_i         (wb_req_i),
  .wbd_bl_i         (wbd_bl_i),
  .wbd_bry_i        (wbd_bry_i),
  .wbd_dat_o        (wbd_dat_o),
  .wbd_ack_o        (wbd_ack_o),
  .wbd_lack_o       (wbd_lack_o),
  .cs_map_i         (cs_map_i),
  .g0_cfg_i         (g0_cfg_i),
  .g1_cfg_i         (g1_cfg_i),
  .spim_reg_req_o   (spim_reg_req_o),
  .spim_reg_o       (spim_reg_o),
  .spim_reg_ack_i   (spim_reg_ack_i),
  .spim_reg_rdata_i (spim_reg_rdata_i),
  .cmd_fifo_wr_o    (cmd_fifo_wr_o),
  .cmd_fifo_wdata_o (cmd_fifo_wdata_o),
  .cmd_fifo_empty_i (cmd_fifo_empty_i),
  .res_fifo_rd_o    (res_fifo_rd_o),
  .res_fifo_rdata_i (res_fifo_rdata_i),
  .res_fifo_empty_i (res_fifo_empty_i)
);

// ==== hdl/qspim_if_top.sv ====
// Top of the read-only QSPI Wishbone front end; ties decoder, read FSM and response stage
module qspim_if_top #(
  parameter int BL_W = 10
) (
  input  logic                                            mclk,
  input  logic                                            rst_n,
  input  logic                                            spi_init_done_i,
  // Wishbone side
  input  qspim_pkg::wb_req_t                              wb_req_i,
  input  logic [BL_W-1:0]                                 wbd_bl_i,
  input  logic                                            wbd_bry_i,
  output logic [qspim_pkg::WB_W-1:0]                      wbd_dat_o,
  output logic                                            wbd_ack_o,
  output logic                                            wbd_lack_o,
  // Configuration
  input  qspim_pkg::spim_cs_map_t [qspim_pkg::NUM_CS-1:0] cs_map_i,
  input  qspim_pkg::spim_rd_cfg_t                         g0_cfg_i,
  input  qspim_pkg::spim_rd_cfg_t                         g1_cfg_i,
  // Register bus, level req/ack
  output logic                                            spim_reg_req_o,
  output qspim_pkg::spim_reg_req_t                        spim_reg_o,
  input  logic                                            spim_reg_ack_i,
  input  logic [qspim_pkg::WB_W-1:0]                      spim_reg_rdata_i,
  // Command FIFO
  output logic                                            cmd_fifo_wr_o,
  output logic [qspim_pkg::CMD_FIFO_WD-1:0]               cmd_fifo_wdata_o,
  input  logic                                            cmd_fifo_full_i,
  input  logic                                            cmd_fifo_empty_i,
  // Response FIFO
  output logic                                            res_fifo_rd_o,
  input  logic [qspim_pkg::WB_W-1:0]                      res_fifo_rdata_i,
  input  logic                                            res_fifo_empty_i
);

  logic                          mem_req;
  logic                          reg_req;
  logic [qspim_pkg::NUM_CS-1:0]  cs;
  qspim_pkg::spim_rd_cfg_t       rd_cfg;
  logic                          mem_ack;
  logic                          mem_last;
  logic [qspim_pkg::WB_W-1:0]    mem_rdata;

  //------------------------------------------------------------
  // Register bus passthrough
  //------------------------------------------------------------
  assign spim_reg_req_o   = reg_req;
  assign spim_reg_o.addr  = wb_req_i.adr[5:2];  // Word address
  assign spim_reg_o.we    = wb_req_i.we;
  assign spim_reg_o.be    = wb_req_i.sel;
  assign spim_reg_o.wdata = wb_req_i.dat;

  qspim_addr_dec u_addr_dec (
    .wb_req_i    (wb_req_i),
    .init_done_i (spi_init_done_i),
    .lack_i      (wbd_lack_o),  // Masks the cycle after the final ack
    .cs_map_i    (cs_map_i),
    .g0_cfg_i    (g0_cfg_i),
    .g1_cfg_i    (g1_cfg_i),
    .mem_req_o   (mem_req),
    .reg_req_o   (reg_req),
    .cs_o        (cs),
    .rd_cfg_o    (rd_cfg)
  );

  qspim_rd_fsm #(.BL_W(BL_W)) u_rd_fsm (
    .mclk             (mclk),
    .rst_n            (rst_n),
    .init_done_i      (spi_init_done_i),
    .mem_req_i        (mem_req),
    .wb_adr_i         (wb_req_i.adr),
    .wbd_bl_i         (wbd_bl_i),
    .wbd_bry_i        (wbd_bry_i),
    .cs_i             (cs),
    .rd_cfg_i         (rd_cfg),
    .cmd_fifo_full_i  (cmd_fifo_full_i),
    .cmd_fifo_empty_i (cmd_fifo_empty_i),
    .res_fifo_empty_i (res_fifo_empty_i),
    .res_fifo_rdata_i (res_fifo_rdata_i),
    .cmd_fifo_wr_o    (cmd_fifo_wr_o),
    .cmd_fifo_wdata_o (cmd_fifo_wdata_o),
    .res_fifo_rd_o    (res_fifo_rd_o),
    .mem_ack_o        (mem_ack),
    .mem_rdata_o      (mem_rdata),
    .mem_last_o       (mem_last)
  );

  qspim_wb_resp #(.BL_W(BL_W)) u_wb_resp (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .mem_req_i   (mem_req),
    .reg_req_i   (reg_req),
    .wb_we_i     (wb_req_i.we),
    .mem_ack_i   (mem_ack),
    .mem_last_i  (mem_last),
    .mem_rdata_i (mem_rdata),
    .reg_ack_i   (spim_reg_ack_i),
    .reg_rdata_i (spim_reg_rdata_i),
    .wbd_ack_o   (wbd_ack_o),
    .wbd_lack_o  (wbd_lack_o),
    .wbd_dat_o   (wbd_dat_o)
  );

endmodule

// ==== hdl/qspim_wb_resp.sv ====
// Registered Wishbone ack, last ack and read data for both register and flash accesses
module qspim_wb_resp #(
  parameter int BL_W = 10
) (
  input  logic                       mclk,
  input  logic                       rst_n,
  input  logic                       mem_req_i,
  input  logic                       reg_req_i,
  input  logic                       wb_we_i,
  input  logic                       mem_ack_i,
  input  logic                       mem_last_i,
  input  logic [qspim_pkg::WB_W-1:0] mem_rdata_i,
  input  logic                       reg_ack_i,
  input  logic [qspim_pkg::WB_W-1:0] reg_rdata_i,
  output logic                       wbd_ack_o,
  output logic                       wbd_lack_o,
  output logic [qspim_pkg::WB_W-1:0] wbd_dat_o
);

  logic                       ack_sel;   // Ack of the active request kind
  logic                       lack_sel;
  logic [qspim_pkg::WB_W-1:0] rdata_sel;

  // A burst longer than the header byte length field can describe is not returnable
  if (BL_W + 2 > qspim_pkg::BYTE_LEN_W) begin : g_bl_chk
    $error("Burst length width does not fit the header byte length field");
  end

  //------------------------------------------------------------
  // Response select
  //------------------------------------------------------------
  assign ack_sel  = mem_req_i ? mem_ack_i : (reg_req_i && reg_ack_i);
  // Register accesses are single beat, so every ack is last
  assign lack_sel = mem_req_i ? (mem_ack_i && mem_last_i) : (reg_req_i && reg_ack_i);

  always_comb begin
    rdata_sel = '0;
    if (ack_sel && !wb_we_i) begin
      rdata_sel = mem_req_i ? mem_rdata_i : reg_rdata_i;
    end
  end

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      wbd_ack_o  <= 1'b0;
      wbd_lack_o <= 1'b0;
      wbd_dat_o  <= '0;
    end else begin
      wbd_ack_o  <= ack_sel;    // One cycle behind the internal ack
      wbd_lack_o <= lack_sel;
      wbd_dat_o  <= rdata_sel;  // Zero outside ack cycles
    end
  end

endmodule

// ==== hdl/qspim_rd_fsm.sv ====
// Builds header and address command words for a flash read, then drains the burst as acks
module qspim_rd_fsm #(
  parameter int BL_W = 10
) (
  input  logic                                mclk,
  input  logic                                rst_n,
  input  logic                                init_done_i,
  input  logic                                mem_req_i,
  input  logic [qspim_pkg::WB_W-1:0]          wb_adr_i,
  input  logic [BL_W-1:0]                     wbd_bl_i,   // Burst length in words
  input  logic                                wbd_bry_i,  // Master ready for a beat
  input  logic [qspim_pkg::NUM_CS-1:0]        cs_i,
  input  qspim_pkg::spim_rd_cfg_t             rd_cfg_i,
  input  logic                                cmd_fifo_full_i,
  input  logic                                cmd_fifo_empty_i,
  input  logic                                res_fifo_empty_i,
  input  logic [qspim_pkg::WB_W-1:0]          res_fifo_rdata_i,
  output logic                                cmd_fifo_wr_o,
  output logic [qspim_pkg::CMD_FIFO_WD-1:0]   cmd_fifo_wdata_o,
  output logic                                res_fifo_rd_o,
  output logic                                mem_ack_o,
  output logic [qspim_pkg::WB_W-1:0]          mem_rdata_o,
  output logic                                mem_last_o   // Final beat of the burst
);

  localparam int                         LEN_W   = qspim_pkg::BYTE_LEN_W;
  localparam logic [qspim_pkg::WB_W-1:0] ADR_INC = qspim_pkg::ADDR_STEP;

  qspim_pkg::qspim_state_e   state, state_nxt;
  logic [BL_W-1:0]           bl_cnt, bl_cnt_nxt;   // Beats left
  logic [qspim_pkg::WB_W-1:0] mem_adr;             // Current flash address
  logic                      mem_req_l;            // Delayed request, for edge detect
  logic [LEN_W-1:0]          byte_len;
  qspim_pkg::spim_cmd_hdr_t  hdr_word;
  qspim_pkg::spim_cmd_adr_t  adr_word;

  //------------------------------------------------------------
  // Command words
  //------------------------------------------------------------
  assign byte_len = LEN_W'(wbd_bl_i) << 2;  // Words to bytes

  always_comb begin
    hdr_word           = '0;
    hdr_word.soc       = 1'b1;
    hdr_word.eoc       = 1'b0;
    hdr_word.byte_len  = byte_len;
    hdr_word.dummy_cnt = rd_cfg_i.dummy_cnt;
    hdr_word.addr_cnt  = rd_cfg_i.addr_cnt;
    hdr_word.switch_pt = rd_cfg_i.switch_pt;
    hdr_word.fmode     = rd_cfg_i.fmode;
    hdr_word.imode     = rd_cfg_i.imode;
    hdr_word.seq       = rd_cfg_i.seq;
    hdr_word.cs        = cs_i;
    hdr_word.mode      = rd_cfg_i.mode;
    hdr_word.cmd       = rd_cfg_i.cmd;
  end

  // Read command always ends with the address word
  assign adr_word = '{soc: 1'b0, eoc: 1'b1, pad: 16'h0, adr: mem_adr};

  //------------------------------------------------------------
  // State and counters
  //------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      state     <= qspim_pkg::IDLE;
      bl_cnt    <= '0;
      mem_req_l <= 1'b0;
    end else begin
      state  <= state_nxt;
      bl_cnt <= bl_cnt_nxt;
      if (init_done_i) mem_req_l <= mem_req_i;  // Hold off until SPI init completes
    end
  end

  // Latch address on a new request, step on every beat
  always_ff @(posedge mclk) begin
    if (init_done_i && mem_req_i && !mem_req_l) begin
      mem_adr <= wb_adr_i;
    end else if (mem_ack_o) begin
      mem_adr <= mem_adr + ADR_INC;
    end
  end

  always_comb begin
    state_nxt        = state;
    bl_cnt_nxt       = bl_cnt;
    cmd_fifo_wr_o    = 1'b0;
    cmd_fifo_wdata_o = '0;
    res_fifo_rd_o    = 1'b0;
    mem_ack_o        = 1'b0;
    mem_rdata_o      = '0;
    mem_last_o       = 1'b0;
    case (state)
      qspim_pkg::IDLE: begin
        // Header goes only into an empty command FIFO
        if (mem_req_i && cmd_fifo_empty_i && !cmd_fifo_full_i) begin
          cmd_fifo_wr_o    = 1'b1;
          cmd_fifo_wdata_o = hdr_word;
          bl_cnt_nxt       = wbd_bl_i;
          state_nxt        = qspim_pkg::ADR_PHASE;
        end
      end
      qspim_pkg::ADR_PHASE: begin
        cmd_fifo_wr_o    = 1'b1;     // Back to back with the header
        cmd_fifo_wdata_o = adr_word;
        state_nxt        = qspim_pkg::CMD_WAIT;
      end
      qspim_pkg::CMD_WAIT: begin
        // Controller has taken both words
        if (cmd_fifo_empty_i) state_nxt = qspim_pkg::READ_DATA;
      end
      qspim_pkg::READ_DATA: begin
        if (!res_fifo_empty_i && wbd_bry_i) begin
          res_fifo_rd_o = 1'b1;
          mem_ack_o     = 1'b1;
          mem_rdata_o   = res_fifo_rdata_i;  // Valid while not empty
          bl_cnt_nxt    = bl_cnt - 1'b1;
          if (bl_cnt <= BL_W'(1)) begin
            mem_last_o = 1'b1;
            state_nxt  = qspim_pkg::IDLE;
          end
        end
      end
      default: state_nxt = qspim_pkg::IDLE;
    endcase
  end

endmodule

// ==== hdl/qspim_addr_dec.sv ====
// Splits Wishbone requests into register or flash reads and picks chip select and read config
module qspim_addr_dec (
  input  qspim_pkg::wb_req_t                               wb_req_i,
  input  logic                                             init_done_i,
  input  logic                                             lack_i,    // Last ack of prior access
  input  qspim_pkg::spim_cs_map_t [qspim_pkg::NUM_CS-1:0]  cs_map_i,
  input  qspim_pkg::spim_rd_cfg_t                          g0_cfg_i,  // CS0/CS1
  input  qspim_pkg::spim_rd_cfg_t                          g1_cfg_i,  // CS2/CS3
  output logic                                             mem_req_o,
  output logic                                             reg_req_o,
  output logic [qspim_pkg::NUM_CS-1:0]                     cs_o,
  output qspim_pkg::spim_rd_cfg_t                          rd_cfg_o
);

  logic                          req_vld;   // Qualified strobe
  logic                          reg_space;
  logic [qspim_pkg::CS_MAP_W-1:0] cs_field;

  //------------------------------------------------------------
  // Request classification
  //------------------------------------------------------------
  // Strobe stays high through the lack cycle, so mask it there
  assign req_vld   = wb_req_i.stb && init_done_i && !lack_i;
  assign reg_space = wb_req_i.adr[qspim_pkg::REG_SEL_BIT];

  assign reg_req_o = req_vld && reg_space;
  // Flash writes fall out here and never get an ack
  assign mem_req_o = req_vld && !reg_space && !wb_req_i.we;

  //------------------------------------------------------------
  // Chip select decode on adr[27:20]
  //------------------------------------------------------------
  assign cs_field = wb_req_i.adr[qspim_pkg::CS_MAP_HI:qspim_pkg::CS_MAP_LO];

  always_comb begin
    for (int i = 0; i < qspim_pkg::NUM_CS; i++) begin
      // Masked address byte must equal the map entry
      cs_o[i] = ((cs_field & cs_map_i[i].mask) == cs_map_i[i].addr);
    end
  end

  // Group 1 only for a clean CS2 or CS3 hit
  always_comb begin
    case (cs_o)
      4'b0100, 4'b1000: rd_cfg_o = g1_cfg_i;
      default:          rd_cfg_o = g0_cfg_i;  // CS0/CS1 and odd patterns
    endcase
  end

endmodule

// ==== hdl/qspim_pkg.sv ====
// Shared widths, address map, FSM states and bus structs for the QSPI Wishbone front end
package qspim_pkg;

  //------------------------------------------------------------
  // Widths and address map
  //------------------------------------------------------------
  localparam int WB_W        = 32;  // Wishbone data/address
  localparam int REG_SEL_BIT = 28;  // Set -> register space
  localparam int CS_MAP_HI   = 27;  // CS decode window
  localparam int CS_MAP_LO   = 20;
  localparam int CS_MAP_W    = CS_MAP_HI - CS_MAP_LO + 1;
  localparam int NUM_CS      = 4;
  localparam int CMD_FIFO_WD = 50;  // Command FIFO word
  localparam int BYTE_LEN_W  = 12;  // Byte length field in header
  localparam int ADDR_STEP   = 4;   // One word per burst beat

  // Read path FSM
  typedef enum logic [3:0] {
    IDLE      = 4'd0,
    ADR_PHASE = 4'd1,
    CMD_WAIT  = 4'd2,
    READ_DATA = 4'd3
  } qspim_state_e;

  //------------------------------------------------------------
  // Bus and configuration structs
  //------------------------------------------------------------
  typedef struct packed {
    logic            stb;
    logic [WB_W-1:0] adr;
    logic            we;
    logic [WB_W-1:0] dat;
    logic [3:0]      sel;
  } wb_req_t;

  typedef struct packed {
    logic [CS_MAP_W-1:0] addr;  // Match value on adr[27:20]
    logic [CS_MAP_W-1:0] mask;  // Bits taking part in the match
  } spim_cs_map_t;

  typedef struct packed {
    logic [1:0] imode;      // Init SPI mode
    logic [1:0] fmode;      // Final SPI mode
    logic [1:0] switch_pt;  // Where the mode switches
    logic [3:0] seq;
    logic [1:0] addr_cnt;
    logic [3:0] dummy_cnt;
    logic [7:0] cmd;        // Flash opcode
    logic [7:0] mode;
  } spim_rd_cfg_t;

  typedef struct packed {
    logic                  soc;
    logic                  eoc;
    logic [BYTE_LEN_W-1:0] byte_len;
    logic [3:0]            dummy_cnt;
    logic [1:0]            addr_cnt;
    logic [1:0]            switch_pt;
    logic [1:0]            fmode;
    logic [1:0]            imode;
    logic [3:0]            seq;
    logic [NUM_CS-1:0]     cs;  // One-hot
    logic [7:0]            mode;
    logic [7:0]            cmd;
  } spim_cmd_hdr_t;

  typedef struct packed {
    logic            soc;
    logic            eoc;
    logic [15:0]     pad;
    logic [WB_W-1:0] adr;
  } spim_cmd_adr_t;

  typedef struct packed {
    logic [3:0]      addr;   // Word address
    logic            we;
    logic [3:0]      be;
    logic [WB_W-1:0] wdata;
  } spim_reg_req_t;

endpackage
